// ==== icache_checker.sv ====
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_checker
    import icache_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  logic                  fetch_valid,
    input  logic [`ADDR_SIZE-1:0] fetch_pc,
    input  logic                  stall,
    input  logic                  inst_valid,
    input  word_t                 inst,
    input  logic [`ADDR_SIZE-1:0] inst_pc,
    input  logic                  mem_req,
    input  logic [`ADDR_SIZE-1:0] mem_addr,
    output int                    errors,
    output int                    refills,
    output int                    pending
);

    logic [`ADDR_SIZE-1:0] pc_q [$];
    logic [`ADDR_SIZE-1:0] req_q [$];
    logic [`TAG_SIZE-1:0]  tag_m [`SET_NUM][`WAY_NUM];
    logic                  val_m [`SET_NUM][`WAY_NUM];
    logic                  lru_m [`SET_NUM];
    logic                  req_seen;
    logic                  req_killed;
    logic [`ADDR_SIZE-1:0] exp_pc;
    word_t                 exp_inst;
    logic [`ADDR_SIZE-1:0] exp_addr;

    initial begin
        errors = 0;
        refills = 0;
        req_seen = 1'b0;
        req_killed = 1'b0;
    end

    // memory returns address xor a fixed pattern
    function automatic word_t expected_word(input logic [`ADDR_SIZE-1:0] pc);
        return {pc[31:2], 2'b00} ^ 32'hA5A5_0000;
    endfunction

    // two-way tag store with one lru bit per set
    task automatic predict(input logic [`ADDR_SIZE-1:0] pc);
        int idx;
        logic [`TAG_SIZE-1:0] tag;
        int w;
        idx = pc[11:5];
        tag = pc[31:12];
        for (w = 0; w < `WAY_NUM; w++) begin
            if (val_m[idx][w] && tag_m[idx][w] == tag) begin
                lru_m[idx] = (w == 0);
                return;
            end
        end
        w = lru_m[idx];
        tag_m[idx][w] = tag;
        val_m[idx][w] = 1'b1;
        lru_m[idx] = (w == 0);
        req_q.push_back({pc[31:5], 5'b0});
    endtask

    always @(posedge clk) begin
        if (reset) begin
            pc_q.delete();
            req_q.delete();
            req_seen = 1'b0;
            req_killed = 1'b0;
            for (int s = 0; s < `SET_NUM; s++) begin
                val_m[s][0] = 1'b0;
                val_m[s][1] = 1'b0;
                lru_m[s] = 1'b0;
            end
        end else begin
            if (inst_valid) begin
                if (pc_q.size() == 0) begin
                    $display("ERROR: inst_valid with no fetch outstanding at %0t", $time);
                    errors++;
                end else begin
                    exp_pc = pc_q.pop_front();
                    exp_inst = expected_word(exp_pc);
                    if (inst_pc !== exp_pc) begin
                        $display("MISMATCH inst_pc: got %h expected %h", inst_pc, exp_pc);
                        errors++;
                    end
                    if (inst !== exp_inst) begin
                        $display("MISMATCH inst: got %h expected %h", inst, exp_inst);
                        errors++;
                    end
                end
            end
            // flush kills everything not yet returned
            if (flush) begin
                pc_q.delete();
            end
            if (fetch_valid && !stall && !flush) begin
                pc_q.push_back(fetch_pc);
                predict(fetch_pc);
            end
            if (mem_req && !req_seen) begin
                refills++;
                req_killed = 1'b0;
                if (req_q.size() == 0) begin
                    $display("ERROR: refill requested for a line already resident");
                    errors++;
                end else begin
                    exp_addr = req_q.pop_front();
                    if (mem_addr !== exp_addr) begin
                        $display("MISMATCH mem_addr: got %h expected %h", mem_addr, exp_addr);
                        errors++;
                    end
                end
            end
            // only a flushed refill runs on without a stall
            if (mem_req && !req_killed && !stall) begin
                $display("ERROR: stall low while a refill was pending at %0t", $time);
                errors++;
            end
            if (flush && mem_req) begin
                req_killed = 1'b1;
            end
            req_seen = mem_req;
        end
        pending = pc_q.size() + req_q.size();
    end

endmodule

// ==== icache_consts.svh ====
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// address and word widths
`define ADDR_SIZE 32
`define DATA_SIZE 32

// address split
`define TAG_SIZE 20
`define INDEX_SIZE 7
`define OFFSET_SIZE 5
`define WORD_SEL_SIZE 3

// geometry
`define BANK_NUM 8
`define SET_NUM 128
`define WAY_NUM 2
`define LINE_SIZE 256

`endif

// ==== icache_lookup.sv ====
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_lookup
    import icache_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   fetch_valid,
    input  logic [`ADDR_SIZE-1:0]  fetch_pc,
    input  logic                   hold,
    output logic                   stall,
    output logic [`INDEX_SIZE-1:0] rd_index,
    output logic                   s1_valid,
    output fetch_addr_u            s1_addr
);

    fetch_addr_u in_addr;

    assign in_addr.raw = fetch_pc;

    // the core only ever sees the refill hold
    assign stall = hold;

    // reread the held set while a miss is pending,
    // else start the read for the incoming fetch
    assign rd_index = hold ? s1_addr.f.index : in_addr.f.index;

    // stage 1 valid
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            s1_valid <= 1'b0;
        end else if (!hold) begin
            s1_valid <= fetch_valid;
        end
    end

    // stage 1 address
    always_ff @(posedge clk) begin
        if (!hold) begin
            s1_addr <= in_addr;
        end
    end

endmodule

// ==== icache_pkg.sv ====
`include "icache_consts.svh"

package icache_pkg;

    // one instruction word
    typedef logic [`DATA_SIZE-1:0] word_t;

    // word k sits at bits 32k+31 down to 32k
    typedef logic [`LINE_SIZE-1:0] line_t;

    // fetch address, raw or split into its cache fields
    typedef union packed {
        logic [`ADDR_SIZE-1:0] raw;
        struct packed {
            logic [`TAG_SIZE-1:0]                     tag;
            logic [`INDEX_SIZE-1:0]                   index;
            logic [`WORD_SEL_SIZE-1:0]                word_sel;
            logic [`OFFSET_SIZE-`WORD_SEL_SIZE-1:0]   byte_off;
        } f;
    } fetch_addr_u;

endpackage

// ==== icache_refill.sv ====
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_refill
    import icache_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   s1_valid,
    input  fetch_addr_u            s1_addr,
    input  logic [`WAY_NUM-1:0]    hit,
    input  word_t                  rd_word [`WAY_NUM],
    output logic                   hold,
    output logic [`WAY_NUM-1:0]    way_we,
    output logic [`INDEX_SIZE-1:0] wr_index,
    output logic [`TAG_SIZE-1:0]   wr_tag,
    output line_t                  wr_line,
    output logic                   mem_req,
    output logic [`ADDR_SIZE-1:0]  mem_addr,
    input  logic                   mem_ack,
    input  line_t                  mem_data,
    output logic                   inst_valid,
    output word_t                  inst,
    output logic [`ADDR_SIZE-1:0]  inst_pc
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_REQ = 2'd1;
    localparam logic [1:0] ST_RELEASE = 2'd2;

    logic [1:0]          state;
    fetch_addr_u         req_addr;
    logic                req_live;
    logic                served;
    logic [`SET_NUM-1:0] lru;

    logic  s1_live;
    logic  s1_hit;
    logic  s1_miss;
    logic  start;
    logic  done;
    logic  victim;
    word_t hit_word;
    word_t fill_word;

    // stage 1 still holds the item just filled for one cycle
    assign s1_live = s1_valid && !served;
    assign s1_hit = s1_live && (|hit);
    assign s1_miss = s1_live && !(|hit);
    assign hold = s1_miss;

    assign start = (state == ST_IDLE) && s1_miss && !flush;
    assign done = (state == ST_REQ) && mem_ack;

    // lru bit names the victim way of the set
    assign victim = lru[req_addr.f.index];

    assign wr_index = req_addr.f.index;
    assign wr_tag = req_addr.f.tag;
    assign wr_line = mem_data;
    assign fill_word = mem_data[req_addr.f.word_sel*`DATA_SIZE +: `DATA_SIZE];

    assign mem_req = (state == ST_REQ);
    assign mem_addr = {req_addr.f.tag, req_addr.f.index, {`OFFSET_SIZE{1'b0}}};

    always_comb begin
        way_we = '0;
        if (done) begin
            way_we[victim] = 1'b1;
        end
    end

    always_comb begin
        hit_word = rd_word[0];
        for (int w = 1; w < `WAY_NUM; w++) begin
            if (hit[w]) begin
                hit_word = rd_word[w];
            end
        end
    end

    // four-phase handshake
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (mem_ack) begin
                        state <= ST_RELEASE;
                    end
                end
                ST_RELEASE: begin
                    // wait for ack low before any new request
                    if (!mem_ack) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            req_addr <= s1_addr;
        end
    end

    // a flushed request still fills but returns nothing
    always_ff @(posedge clk) begin
        if (reset) begin
            req_live <= 1'b0;
            served <= 1'b0;
        end else begin
            if (start) begin
                req_live <= 1'b1;
            end else if (flush || done) begin
                req_live <= 1'b0;
            end
            served <= done && req_live;
        end
    end

    // the other way becomes lru
    always_ff @(posedge clk) begin
        if (reset) begin
            lru <= '0;
        end else begin
            if (s1_hit) begin
                lru[s1_addr.f.index] <= hit[0];
            end
            if (done) begin
                lru[req_addr.f.index] <= ~victim;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            inst_valid <= 1'b0;
        end else begin
            inst_valid <= !flush && (s1_hit || (done && req_live));
        end
    end

    // output word, from a way or forwarded from memory
    always_ff @(posedge clk) begin
        if (s1_hit) begin
            inst <= hit_word;
            inst_pc <= s1_addr.raw;
        end else if (done) begin
            inst <= fill_word;
            inst_pc <= req_addr.raw;
        end
    end

endmodule

// ==== icache_sva.sv ====
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_sva (
    input logic                  clk,
    input logic                  reset,
    input logic                  mem_req,
    input logic [`ADDR_SIZE-1:0] mem_addr,
    input logic                  mem_ack
);

    int fails = 0;

    // request address held for the whole request
    assert property (@(posedge clk) disable iff (reset)
        (mem_req && $past(mem_req)) |-> $stable(mem_addr))
        else begin
            fails++;
            $error("mem_addr changed while mem_req was high");
        end

    // a new request only after the previous ack dropped
    assert property (@(posedge clk) disable iff (reset)
        $rose(mem_req) |-> !mem_ack)
        else begin
            fails++;
            $error("mem_req rose while mem_ack was high");
        end

    assert property (@(posedge clk) reset |=> !mem_req)
        else begin
            fails++;
            $error("mem_req high after reset");
        end

endmodule

bind icache_top icache_sva u_sva (
    .clk      (clk),
    .reset    (reset),
    .mem_req  (mem_req),
    .mem_addr (mem_addr),
    .mem_ack  (mem_ack)
);

// ==== icache_tb.sv ====
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_tb;
    import icache_pkg::*;

    localparam int NUM_ROWS = 21;
    // worst refill is about 12 cycles so 20 per row leaves room
    localparam int TIMEOUT_NS = (16 + NUM_ROWS * 20 + 200) * 4;

    logic                  clk;
    logic                  reset;
    logic                  flush;
    logic                  fetch_valid;
    logic [`ADDR_SIZE-1:0] fetch_pc;
    logic                  stall;
    logic                  inst_valid;
    word_t                 inst;
    logic [`ADDR_SIZE-1:0] inst_pc;
    logic                  mem_req;
    logic [`ADDR_SIZE-1:0] mem_addr;
    logic                  mem_ack;
    line_t                 mem_data;
    int                    errors;
    int                    refills;
    int                    pending;
    int                    tb_errors;
    int                    exp_refills;
    logic [31:0]           seed;

    // pc, flush, expected refill
    logic [33:0] table_rows [NUM_ROWS];

    tb_clock u_clock (.clk(clk));

    icache_top uut (.*);

    icache_checker u_checker (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic line_t build_line(input logic [`ADDR_SIZE-1:0] a);
        line_t l;
        for (int k = 0; k < `BANK_NUM; k++) begin
            l[k*`DATA_SIZE +: `DATA_SIZE] = (a + 4 * k) ^ 32'hA5A5_0000;
        end
        return l;
    endfunction

    task automatic load_table();
        table_rows[0] = {32'h0000_1000, 1'b0, 1'b1};
        table_rows[1] = {32'h0000_1004, 1'b0, 1'b0};
        table_rows[2] = {32'h0000_1008, 1'b0, 1'b0};
        table_rows[3] = {32'h0000_100C, 1'b0, 1'b0};
        table_rows[4] = {32'h0000_1010, 1'b0, 1'b0};
        table_rows[5] = {32'h0000_1014, 1'b0, 1'b0};
        table_rows[6] = {32'h0000_1018, 1'b0, 1'b0};
        table_rows[7] = {32'h0000_101C, 1'b0, 1'b0};
        // set 2, two tags resident
        table_rows[8] = {32'h0000_2040, 1'b0, 1'b1};
        table_rows[9] = {32'h0000_3044, 1'b0, 1'b1};
        table_rows[10] = {32'h0000_2048, 1'b0, 1'b0};
        table_rows[11] = {32'h0000_304C, 1'b0, 1'b0};
        table_rows[12] = {32'h0000_2050, 1'b0, 1'b0};
        // third tag evicts 0x3000
        table_rows[13] = {32'h0000_4054, 1'b0, 1'b1};
        table_rows[14] = {32'h0000_2058, 1'b0, 1'b0};
        table_rows[15] = {32'h0000_305C, 1'b0, 1'b1};
        table_rows[16] = {32'h0000_2040, 1'b0, 1'b0};
        // miss interrupted by flush, line still filled
        table_rows[17] = {32'h0000_5100, 1'b1, 1'b1};
        table_rows[18] = {32'h0000_5104, 1'b0, 1'b0};
        table_rows[19] = {32'h0000_6200, 1'b0, 1'b1};
        table_rows[20] = {32'h0000_6204, 1'b0, 1'b0};
    endtask

    // four-phase memory with random ack delay
    initial begin
        int delay;
        mem_ack = 1'b0;
        mem_data = '0;
        seed = 32'h7558_792a;
        forever begin
            @(negedge clk);
            if (mem_req && !reset) begin
                seed = lcg_next(seed);
                delay = 1 + (seed[23:16] % 6);
                repeat (delay) @(negedge clk);
                mem_data = build_line(mem_addr);
                mem_ack = 1'b1;
                do @(negedge clk); while (mem_req);
                mem_ack = 1'b0;
                mem_data = '0;
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish in time");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        reset = 1'b1;
        flush = 1'b0;
        fetch_valid = 1'b0;
        fetch_pc = '0;
        tb_errors = 0;
        exp_refills = 0;
        load_table();
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            exp_refills += table_rows[r][0];
            fetch_valid = 1'b1;
            fetch_pc = table_rows[r][33:2];
            // held until a cycle without stall
            #1;
            while (stall) begin
                @(negedge clk);
                #1;
            end
            @(negedge clk);
            fetch_valid = 1'b0;
            if (table_rows[r][1]) begin
                while (!mem_req) @(negedge clk);
                flush = 1'b1;
                @(negedge clk);
                flush = 1'b0;
            end
        end
        // drain
        do @(negedge clk); while (pending != 0 || mem_req || mem_ack || stall);
        repeat (4) @(negedge clk);
        if (refills != exp_refills) begin
            $display("MISMATCH refills: got %h expected %h", refills, exp_refills);
            tb_errors++;
        end
        $display("checker errors %0d, testbench errors %0d, assertion failures %0d, refills %0d",
                 errors, tb_errors, uut.u_sva.fails, refills);
        if (errors == 0 && tb_errors == 0 && uut.u_sva.fails == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== icache_top.sv ====
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_top
    import icache_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  logic                  fetch_valid,
    input  logic [`ADDR_SIZE-1:0] fetch_pc,
    output logic                  stall,
    output logic                  inst_valid,
    output word_t                 inst,
    output logic [`ADDR_SIZE-1:0] inst_pc,
    output logic                  mem_req,
    output logic [`ADDR_SIZE-1:0] mem_addr,
    input  logic                  mem_ack,
    input  line_t                 mem_data
);

    logic                   hold;
    logic [`INDEX_SIZE-1:0] rd_index;
    logic                   s1_valid;
    fetch_addr_u            s1_addr;
    logic [`WAY_NUM-1:0]    hit;
    word_t                  rd_word [`WAY_NUM];
    logic [`WAY_NUM-1:0]    way_we;
    logic [`INDEX_SIZE-1:0] wr_index;
    logic [`TAG_SIZE-1:0]   wr_tag;
    line_t                  wr_line;

    icache_lookup u_lookup (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .hold        (hold),
        .stall       (stall),
        .rd_index    (rd_index),
        .s1_valid    (s1_valid),
        .s1_addr     (s1_addr)
    );

    for (genvar w = 0; w < `WAY_NUM; w++) begin : g_way
        icache_way u_way (
            .clk      (clk),
            .reset    (reset),
            .rd_index (rd_index),
            .cmp_tag  (s1_addr.f.tag),
            .word_sel (s1_addr.f.word_sel),
            .we       (way_we[w]),
            .wr_index (wr_index),
            .wr_tag   (wr_tag),
            .wr_line  (wr_line),
            .hit      (hit[w]),
            .rd_word  (rd_word[w])
        );
    end

    icache_refill u_refill (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .s1_valid   (s1_valid),
        .s1_addr    (s1_addr),
        .hit        (hit),
        .rd_word    (rd_word),
        .hold       (hold),
        .way_we     (way_we),
        .wr_index   (wr_index),
        .wr_tag     (wr_tag),
        .wr_line    (wr_line),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_ack    (mem_ack),
        .mem_data   (mem_data),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_pc    (inst_pc)
    );

endmodule

// ==== icache_way.sv ====
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_way
    import icache_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic [`INDEX_SIZE-1:0]    rd_index,
    input  logic [`TAG_SIZE-1:0]      cmp_tag,
    input  logic [`WORD_SEL_SIZE-1:0] word_sel,
    input  logic                      we,
    input  logic [`INDEX_SIZE-1:0]    wr_index,
    input  logic [`TAG_SIZE-1:0]      wr_tag,
    input  line_t                     wr_line,
    output logic                      hit,
    output word_t                     rd_word
);

    logic [`TAG_SIZE-1:0] tag_mem [`SET_NUM];
    logic [`SET_NUM-1:0]  valid_mem;

    logic [`TAG_SIZE-1:0] rd_tag;
    logic                 rd_valid;
    word_t                rd_bank [`BANK_NUM];
    logic                 bypass;

    // a line written into the set under read is seen on the same edge
    assign bypass = we && (wr_index == rd_index);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_mem <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (we) begin
                valid_mem[wr_index] <= 1'b1;
            end
            rd_valid <= bypass ? 1'b1 : valid_mem[rd_index];
        end
    end

    // tag array
    always_ff @(posedge clk) begin
        if (we) begin
            tag_mem[wr_index] <= wr_tag;
        end
        rd_tag <= bypass ? wr_tag : tag_mem[rd_index];
    end

    // one bank per word of the line
    for (genvar b = 0; b < `BANK_NUM; b++) begin : g_bank
        word_t bank_mem [`SET_NUM];
        word_t wr_word;

        assign wr_word = wr_line[b*`DATA_SIZE +: `DATA_SIZE];

        always_ff @(posedge clk) begin
            if (we) begin
                bank_mem[wr_index] <= wr_word;
            end
            rd_bank[b] <= bypass ? wr_word : bank_mem[rd_index];
        end
    end

    // compare in the cycle after the read
    assign hit = rd_valid && (rd_tag == cmp_tag);
    assign rd_word = rd_bank[word_sel];

endmodule

// ==== list.f ====
+incdir+.
icache_pkg.sv
icache_way.sv
icache_lookup.sv
icache_refill.sv
icache_top.sv
tb_clock.sv
icache_checker.sv
icache_sva.sv
icache_tb.sv

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

endmodule
